//--- flist.f
+incdir+tb
verilog/tomasulo_pkg.sv
verilog/tomasulo_inst_fifo.sv
verilog/tomasulo_dispatcher.sv
verilog/tomasulo_rs.sv
verilog/tomasulo_exe_pipe.sv
verilog/tomasulo_cdb.sv
verilog/tomasulo.sv
tb/tomasulo_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tomasulo_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully

SOURCES := $(wildcard verilog/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/tomasulo_tb_model.svh
// Reference model for the default core; include inside the testbench module after err_cnt and check_cnt
`ifndef TOMASULO_TB_MODEL_SVH
`define TOMASULO_TB_MODEL_SVH

// One expected result, keyed by destination register and value
typedef struct packed {
  reg_t  wa;
  word_t data;
} exp_t;

// Architectural registers in program order
word_t model_regs [8];
// Results that are owed by the core, in no particular order
exp_t  pool [$];

// Arithmetic of one instruction, taken from the opcode definitions
function automatic word_t expected_value(input opcode_t op, input word_t a, input word_t b);
  logic [31:0] prod;
  word_t       res;
  prod = {16'h0000, a} * {16'h0000, b};
  case (op)
    OP_ADD:  res = a + b;
    OP_SUB:  res = a - b;
    // Only the low half of the product reaches the register
    OP_MPY:  res = prod[15:0];
    default: res = '0;
  endcase
  return res;
endfunction

// After reset register i holds i
function automatic void model_reset();
  for (int i = 0; i < 8; i++)
    model_regs[i] = word_t'(i);
  pool.delete();
endfunction

// Called once per accepted instruction, so the register reads follow program order
function automatic void model_accept(input opcode_t op, input reg_t wa, input reg_t ra0,
                                     input reg_t ra1);
  word_t res;
  exp_t  e;
  res = expected_value(op, model_regs[ra0], model_regs[ra1]);
  model_regs[wa] = res;
  e.wa   = wa;
  e.data = res;
  pool.push_back(e);
endfunction

// Results may complete out of order, so any pending pair with the same register and value matches
task automatic compare_result(input reg_t wa, input word_t data);
  int hit;
  int near;
  hit  = -1;
  near = -1;
  check_cnt++;
  foreach (pool[i])
  begin
    if (hit < 0 && pool[i].wa == wa && pool[i].data == data)
      hit = i;
    if (near < 0 && pool[i].wa == wa)
      near = i;
  end
  if (hit >= 0)
    pool.delete(hit);
  else if (near >= 0)
  begin
    $display("MISMATCH out_wdata_r for out_wa_r %h: got %h, expected %h",
             wa, data, pool[near].data);
    err_cnt++;
  end
  else
  begin
    $display("ERROR: result %h for register %0d arrived but none was owed", data, wa);
    err_cnt++;
  end
endtask

`endif

//--- tb/tomasulo_tb.sv
// Self-checking testbench for the default parameters; the first timeout skips the remaining tests
`timescale 1ns/1ps
`default_nettype none

module tomasulo_tb;
  import tomasulo_pkg::*;

  localparam int SEND_TIMEOUT_N  = 500;
  localparam int DRAIN_TIMEOUT_N = 3000;

  logic    clk;
  logic    rst;
  logic    in_pass;
  reg_t    in_inst_ra_1;
  reg_t    in_inst_ra_0;
  reg_t    in_inst_wa;
  opcode_t in_inst_op;
  logic    in_accept;
  logic    out_vld_r;
  reg_t    out_wa_r;
  word_t   out_wdata_r;

  integer seed = 32'hab31_b17b;
  int     err_cnt;
  int     check_cnt;
  int     test_cnt;
  int     test_fail_cnt;
  int     test_err_base;
  // Set by the monitor whenever the queue pushes back
  logic   accept_low_seen;
  // Set on the first timeout so that the remaining steps are skipped
  logic   aborted;

  `include "tomasulo_tb_model.svh"

  tomasulo #(
    .FIFO_DEPTH_LOG2(4),
    .LATENCY_ARITH_N(2),
    .LATENCY_MPY_N(4)
  ) dut_i (
    .clk(clk), .rst(rst), .in_pass(in_pass), .in_inst_ra_1(in_inst_ra_1),
    .in_inst_ra_0(in_inst_ra_0), .in_inst_wa(in_inst_wa), .in_inst_op(in_inst_op),
    .in_accept(in_accept), .out_vld_r(out_vld_r), .out_wa_r(out_wa_r),
    .out_wdata_r(out_wdata_r)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (out_vld_r)
        compare_result(out_wa_r, out_wdata_r);
      if (!in_accept)
        accept_low_seen = 1'b1;
    end
  end

  task automatic finish_run();
    $display("summary: %0d tests, %0d failing, %0d results checked, %0d errors",
             test_cnt, test_fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("ERROR: timed out while waiting for %s", what);
    err_cnt++;
    aborted = 1'b1;
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp)
    begin
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic send_inst(input opcode_t op, input reg_t wa, input reg_t ra0, input reg_t ra1);
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    if (!aborted)
    begin
      in_pass      = 1'b1;
      in_inst_op   = op;
      in_inst_wa   = wa;
      in_inst_ra_0 = ra0;
      in_inst_ra_1 = ra1;
      while (!done && waited < SEND_TIMEOUT_N)
      begin
        // in_accept only moves on a clock edge, so this value holds until the transfer edge
        if (in_accept)
        begin
          done = 1'b1;
          model_accept(op, wa, ra0, ra1);
        end
        @(posedge clk);
        #1;
        waited++;
      end
      in_pass = 1'b0;
      if (!done)
        report_timeout("in_accept to rise");
    end
  endtask

  task automatic send_random();
    int      pick;
    opcode_t op;
    reg_t    wa;
    reg_t    ra0;
    reg_t    ra1;
    pick = $unsigned($random(seed)) % 3;
    op   = (pick == 0) ? OP_ADD : ((pick == 1) ? OP_SUB : OP_MPY);
    wa   = reg_t'($random(seed));
    ra0  = reg_t'($random(seed));
    ra1  = reg_t'($random(seed));
    send_inst(op, wa, ra0, ra1);
  endtask

  // Every owed result must arrive, then a quiet spell shows up any extra beat
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (!aborted && pool.size() != 0 && waited < DRAIN_TIMEOUT_N)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!aborted)
    begin
      if (pool.size() != 0)
        report_timeout($sformatf("%0d outstanding results", pool.size()));
      else
        idle_cycles(12);
    end
  endtask

  task automatic test_end(input string name);
    test_cnt++;
    if (err_cnt != test_err_base)
    begin
      test_fail_cnt++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
    end
    else if (aborted)
      $display("test %0d %s: skipped", test_cnt, name);
    else
      $display("test %0d %s: ok", test_cnt, name);
    test_err_base = err_cnt;
  endtask

  initial
  begin
    rst             = 1'b1;
    in_pass         = 1'b0;
    in_inst_op      = OP_ADD;
    in_inst_wa      = '0;
    in_inst_ra_0    = '0;
    in_inst_ra_1    = '0;
    accept_low_seen = 1'b0;
    aborted         = 1'b0;
    err_cnt         = 0;
    check_cnt       = 0;
    test_cnt        = 0;
    test_fail_cnt   = 0;
    test_err_base   = 0;
    model_reset();
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // r3 = r1 + r2 straight from the reset values
    send_inst(OP_ADD, 3'd3, 3'd1, 3'd2);
    wait_drain();
    test_end("single add");

    // Each instruction waits on the one before it through its tag
    send_inst(OP_ADD, 3'd1, 3'd1, 3'd2);
    send_inst(OP_MPY, 3'd2, 3'd1, 3'd1);
    send_inst(OP_SUB, 3'd3, 3'd2, 3'd1);
    send_inst(OP_MPY, 3'd1, 3'd3, 3'd2);
    send_inst(OP_ADD, 3'd4, 3'd1, 3'd3);
    wait_drain();
    test_end("dependent chain");

    // The adds do not read r5 and can overtake the multiply
    send_inst(OP_MPY, 3'd5, 3'd6, 3'd7);
    send_inst(OP_ADD, 3'd0, 3'd1, 3'd2);
    send_inst(OP_SUB, 3'd1, 3'd3, 3'd4);
    send_inst(OP_ADD, 3'd2, 3'd0, 3'd3);
    wait_drain();
    test_end("independent after multiply");

    // The slow write to r1 finishes last and must not overwrite the newer value
    send_inst(OP_MPY, 3'd1, 3'd2, 3'd3);
    send_inst(OP_ADD, 3'd1, 3'd4, 3'd5);
    send_inst(OP_ADD, 3'd6, 3'd1, 3'd1);
    wait_drain();
    // This read comes from the register file itself
    send_inst(OP_ADD, 3'd7, 3'd1, 3'd0);
    wait_drain();
    test_end("write after write");

    accept_low_seen = 1'b0;
    for (int i = 0; i < 40; i++)
      send_random();
    if (!aborted)
      check_bit("in_accept low during burst", accept_low_seen, 1'b1);
    wait_drain();
    test_end("burst of 40");

    for (int i = 0; i < 200; i++)
    begin
      send_random();
      idle_cycles($unsigned($random(seed)) % 4);
    end
    wait_drain();
    test_end("random 200");

    finish_run();
  end

endmodule

`default_nettype wire

//--- verilog/tomasulo.sv
// Tomasulo core top; results leave in completion order and the output has no back-pressure
`timescale 1ns/1ps
`default_nettype none

module tomasulo #(
  parameter int FIFO_DEPTH_LOG2 = 4,
  parameter int LATENCY_ARITH_N = 2,
  parameter int LATENCY_MPY_N   = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_pass,
  input  tomasulo_pkg::reg_t    in_inst_ra_1,
  input  tomasulo_pkg::reg_t    in_inst_ra_0,
  input  tomasulo_pkg::reg_t    in_inst_wa,
  input  tomasulo_pkg::opcode_t in_inst_op,
  output logic                  in_accept,
  output logic                  out_vld_r,
  output tomasulo_pkg::reg_t    out_wa_r,
  output tomasulo_pkg::word_t   out_wdata_r
);
  import tomasulo_pkg::*;

  inst_t            fifo_in;
  logic             fifo_push;
  logic             fifo_full_r;
  inst_t            inst;
  logic             inst_vld;
  logic             inst_adv;
  dispatch_t        dis_r;
  logic [1:0]       dis_vld_r;
  logic             arith_full_r;
  logic             mpy_full_r;
  logic [1:0]       cdb_req;
  logic [1:0]       cdb_gnt;
  logic [SCH_W-1:0] sch_r;
  logic             arith_iss_vld;
  issue_t           arith_iss;
  logic             mpy_iss_vld;
  issue_t           mpy_iss;
  cdb_t             arith_cdb;
  cdb_t             mpy_cdb;
  cdb_t             cdb_r;

  assign fifo_in   = '{op: in_inst_op, wa: in_inst_wa, ra0: in_inst_ra_0, ra1: in_inst_ra_1};
  assign in_accept = ~fifo_full_r;
  assign fifo_push = in_pass & in_accept;

  tomasulo_inst_fifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_fifo (
    .clk(clk), .rst(rst), .push(fifo_push), .push_inst(fifo_in), .full_r(fifo_full_r),
    .inst(inst), .inst_vld(inst_vld), .inst_adv(inst_adv)
  );

  tomasulo_dispatcher u_dispatcher (
    .clk(clk), .rst(rst), .inst(inst), .inst_vld(inst_vld), .inst_adv(inst_adv),
    .arith_full_r(arith_full_r), .mpy_full_r(mpy_full_r), .cdb_r(cdb_r),
    .dis_r(dis_r), .dis_vld_r(dis_vld_r),
    .out_vld_r(out_vld_r), .out_wa_r(out_wa_r), .out_wdata_r(out_wdata_r)
  );

  // Station 0 serves add and subtract
  tomasulo_rs u_rs_arith (
    .clk(clk), .rst(rst), .dis_vld_r(dis_vld_r[0]), .dis_r(dis_r), .cdb_r(cdb_r),
    .sch_r(sch_r), .slot_idx(3'(LATENCY_ARITH_N)), .cdb_req(cdb_req[0]),
    .cdb_gnt(cdb_gnt[0]), .full_r(arith_full_r), .iss_vld_r(arith_iss_vld), .iss_r(arith_iss)
  );

  tomasulo_exe_pipe #(.LATENCY_N(LATENCY_ARITH_N)) u_exe_arith (
    .clk(clk), .rst(rst), .iss_vld(arith_iss_vld), .iss(arith_iss), .cdb_r(arith_cdb)
  );

  // Station 1 serves multiply
  tomasulo_rs u_rs_mpy (
    .clk(clk), .rst(rst), .dis_vld_r(dis_vld_r[1]), .dis_r(dis_r), .cdb_r(cdb_r),
    .sch_r(sch_r), .slot_idx(3'(LATENCY_MPY_N)), .cdb_req(cdb_req[1]),
    .cdb_gnt(cdb_gnt[1]), .full_r(mpy_full_r), .iss_vld_r(mpy_iss_vld), .iss_r(mpy_iss)
  );

  tomasulo_exe_pipe #(.LATENCY_N(LATENCY_MPY_N)) u_exe_mpy (
    .clk(clk), .rst(rst), .iss_vld(mpy_iss_vld), .iss(mpy_iss), .cdb_r(mpy_cdb)
  );

  tomasulo_cdb #(.LATENCY_ARITH_N(LATENCY_ARITH_N), .LATENCY_MPY_N(LATENCY_MPY_N)) u_cdb (
    .clk(clk), .rst(rst), .cdb_req(cdb_req), .cdb_gnt(cdb_gnt), .sch_r(sch_r),
    .arith_cdb(arith_cdb), .mpy_cdb(mpy_cdb), .cdb_r(cdb_r)
  );

endmodule

`default_nettype wire

//--- verilog/tomasulo_cdb.sv
// CDB stage for exactly two stations; latencies must be at least 1 and below SCH_W
`timescale 1ns/1ps
`default_nettype none

module tomasulo_cdb #(
  parameter int LATENCY_ARITH_N = 2,
  parameter int LATENCY_MPY_N   = 4
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [1:0]                     cdb_req,
  output logic [1:0]                     cdb_gnt,
  output logic [tomasulo_pkg::SCH_W-1:0] sch_r,
  input  tomasulo_pkg::cdb_t             arith_cdb,
  input  tomasulo_pkg::cdb_t             mpy_cdb,
  output tomasulo_pkg::cdb_t             cdb_r
);
  import tomasulo_pkg::*;

  // Requester that wins a tie this cycle
  logic             prio_r;
  logic [SCH_W-1:0] sch_w;

  always_comb
  begin
    cdb_gnt = '0;
    if (cdb_req[prio_r])
      cdb_gnt[prio_r] = 1'b1;
    else if (cdb_req[~prio_r])
      cdb_gnt[~prio_r] = 1'b1;

    // Bit k of sch_r marks a pipeline output k+1 cycles from now
    sch_w = sch_r >> 1;
    if (cdb_gnt[0])
      sch_w[LATENCY_ARITH_N-1] = 1'b1;
    if (cdb_gnt[1])
      sch_w[LATENCY_MPY_N-1] = 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      prio_r <= 1'b0;
      sch_r  <= '0;
      cdb_r  <= '0;
    end
    else
    begin
      // The loser of this grant goes first next time
      if (|cdb_gnt)
        prio_r <= cdb_gnt[0];
      sch_r <= sch_w;
      cdb_r <= arith_cdb | mpy_cdb;
    end
  end

  // The slot reservations must keep the two pipelines apart on the bus
  a_one_result: assert property (@(posedge clk) disable iff (rst)
    !(arith_cdb.vld && mpy_cdb.vld))
    else $error("CDB collision between pipelines");

endmodule

`default_nettype wire

//--- verilog/tomasulo_exe_pipe.sv
// Fixed-latency pipeline, LATENCY_N must be at least 1; idle stages hold an all-zero CDB word
`timescale 1ns/1ps
`default_nettype none

module tomasulo_exe_pipe #(
  parameter int LATENCY_N = 2
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 iss_vld,
  input  tomasulo_pkg::issue_t iss,
  output tomasulo_pkg::cdb_t   cdb_r
);
  import tomasulo_pkg::*;

  word_t res;
  cdb_t  stg_w;
  cdb_t  stg_r [LATENCY_N];

  always_comb
  begin
    // Multiply keeps the low half of the product
    case (iss.op)
      OP_ADD:  res = iss.val[0] + iss.val[1];
      OP_SUB:  res = iss.val[0] - iss.val[1];
      OP_MPY:  res = iss.val[0] * iss.val[1];
      default: res = '0;
    endcase
    // Zero when idle so the CDB stage can OR pipelines together
    stg_w = '0;
    if (iss_vld)
    begin
      stg_w.vld  = 1'b1;
      stg_w.tag  = iss.tag;
      stg_w.wa   = iss.wa;
      stg_w.data = res;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < LATENCY_N; i++)
        stg_r[i] <= '0;
    end
    else
    begin
      stg_r[0] <= stg_w;
      for (int i = 1; i < LATENCY_N; i++)
        stg_r[i] <= stg_r[i-1];
    end
  end

  assign cdb_r = stg_r[LATENCY_N-1];

endmodule

`default_nettype wire

//--- verilog/tomasulo_rs.sv
// Reservation station of two entries, issue is oldest ready first; slot_idx is the pipeline latency
`timescale 1ns/1ps
`default_nettype none

module tomasulo_rs (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           dis_vld_r,
  input  tomasulo_pkg::dispatch_t        dis_r,
  input  tomasulo_pkg::cdb_t             cdb_r,
  input  logic [tomasulo_pkg::SCH_W-1:0] sch_r,
  input  logic [2:0]                     slot_idx,
  output logic                           cdb_req,
  input  logic                           cdb_gnt,
  output logic                           full_r,
  output logic                           iss_vld_r,
  output tomasulo_pkg::issue_t           iss_r
);
  import tomasulo_pkg::*;

  logic [RS_ENTRIES_N-1:0]          ent_vld_r;
  logic [RS_ENTRIES_N-1:0]          ent_vld_w;
  dispatch_t                        ent_r [RS_ENTRIES_N];
  dispatch_t                        ent_w [RS_ENTRIES_N];
  logic [RS_ENTRIES_N-1:0]          rdy;
  logic [$clog2(RS_ENTRIES_N+1)-1:0] vld_cnt;
  // Index of the older entry when both are valid
  logic                             old_r;
  logic                             sel;
  logic                             wr_idx;
  logic                             full_w;

  // Snoop the CDB for an operand still waiting on its tag
  function automatic operand_t capture(input operand_t o, input cdb_t c);
    operand_t r;
    r = o;
    if (!o.rdy && c.vld && (c.tag == o.tag))
    begin
      r.rdy = 1'b1;
      r.val = c.data;
    end
    return r;
  endfunction

  always_comb
  begin
    for (int i = 0; i < RS_ENTRIES_N; i++)
      rdy[i] = ent_vld_r[i] & ent_r[i].src[0].rdy & ent_r[i].src[1].rdy;
    sel     = rdy[old_r] ? old_r : ~old_r;
    wr_idx  = ent_vld_r[0];
    // The result slot must be free on the CDB LATENCY cycles after issue
    cdb_req = (|rdy) & ~sch_r[slot_idx];

    ent_w     = ent_r;
    ent_vld_w = ent_vld_r;
    for (int i = 0; i < RS_ENTRIES_N; i++)
      for (int j = 0; j < 2; j++)
        ent_w[i].src[j] = capture(ent_r[i].src[j], cdb_r);
    // The entry is released as soon as it issues
    if (cdb_gnt)
      ent_vld_w[sel] = 1'b0;
    // A dispatch can meet its producer's broadcast in the same cycle
    if (dis_vld_r)
    begin
      ent_vld_w[wr_idx] = 1'b1;
      ent_w[wr_idx]     = dis_r;
      for (int j = 0; j < 2; j++)
        ent_w[wr_idx].src[j] = capture(dis_r.src[j], cdb_r);
    end

    vld_cnt = '0;
    for (int i = 0; i < RS_ENTRIES_N; i++)
      vld_cnt = vld_cnt + ent_vld_w[i];
    // One entry is kept back for a dispatch that may already be in flight
    full_w = (vld_cnt >= RS_ENTRIES_N - 1);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ent_vld_r <= '0;
      old_r     <= 1'b0;
      full_r    <= 1'b0;
      iss_vld_r <= 1'b0;
    end
    else
    begin
      ent_vld_r <= ent_vld_w;
      full_r    <= full_w;
      iss_vld_r <= cdb_gnt;
      // The newcomer is older only if it is alone
      if (dis_vld_r)
        old_r <= ent_vld_w[~wr_idx] ? ~wr_idx : wr_idx;
      else if (cdb_gnt && (sel == old_r))
        old_r <= ~old_r;
    end
  end

  always_ff @(posedge clk)
  begin
    ent_r <= ent_w;
    if (cdb_gnt)
    begin
      iss_r.op     <= ent_r[sel].op;
      iss_r.wa     <= ent_r[sel].wa;
      iss_r.tag    <= ent_r[sel].tag;
      iss_r.val[0] <= ent_r[sel].src[0].val;
      iss_r.val[1] <= ent_r[sel].src[1].val;
    end
  end

  // The dispatcher must never target a station whose entries are all taken
  a_no_dis_full: assert property (@(posedge clk) disable iff (rst)
    dis_vld_r |-> !(&ent_vld_r))
    else $error("dispatch into full reservation station");

endmodule

`default_nettype wire

//--- verilog/tomasulo_dispatcher.sv
// In-order dispatch; two rename tags per station, a tag is not reused until its result is broadcast
`timescale 1ns/1ps
`default_nettype none

module tomasulo_dispatcher (
  input  logic                    clk,
  input  logic                    rst,
  input  tomasulo_pkg::inst_t     inst,
  input  logic                    inst_vld,
  output logic                    inst_adv,
  input  logic                    arith_full_r,
  input  logic                    mpy_full_r,
  input  tomasulo_pkg::cdb_t      cdb_r,
  output tomasulo_pkg::dispatch_t dis_r,
  output logic [1:0]              dis_vld_r,
  output logic                    out_vld_r,
  output tomasulo_pkg::reg_t      out_wa_r,
  output tomasulo_pkg::word_t     out_wdata_r
);
  import tomasulo_pkg::*;

  // Architectural state and the rename table
  word_t     regs_r    [8];
  logic      ren_vld_r [8];
  tag_t      ren_tag_r [8];
  // A tag stays busy from dispatch until its result is on the CDB
  logic [3:0] busy_r;

  logic      stn;
  logic      stn_full;
  logic      tag_free;
  tag_t      new_tag;
  dispatch_t dis_w;

  // Value from the register file, from this cycle's broadcast, or else a tag to wait on
  function automatic operand_t src_operand(input reg_t ra);
    operand_t o;
    o.rdy = 1'b1;
    o.tag = ren_tag_r[ra];
    o.val = regs_r[ra];
    if (ren_vld_r[ra])
    begin
      if (cdb_r.vld && (cdb_r.tag == ren_tag_r[ra]))
        o.val = cdb_r.data;
      else
      begin
        o.rdy = 1'b0;
        o.val = '0;
      end
    end
    return o;
  endfunction

  always_comb
  begin
    // Multiplies go to station 1, everything else to station 0
    stn      = (inst.op == OP_MPY);
    stn_full = stn ? mpy_full_r : arith_full_r;
    // Take slot 0 of the station's tags if it is free, otherwise slot 1
    new_tag  = {stn, busy_r[{stn, 1'b0}]};
    tag_free = ~(busy_r[{stn, 1'b0}] & busy_r[{stn, 1'b1}]);
    inst_adv = inst_vld & ~stn_full & tag_free;

    dis_w.op     = inst.op;
    dis_w.wa     = inst.wa;
    dis_w.tag    = new_tag;
    dis_w.src[0] = src_operand(inst.ra0);
    dis_w.src[1] = src_operand(inst.ra1);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < 8; i++)
      begin
        regs_r[i]    <= word_t'(i);
        ren_vld_r[i] <= 1'b0;
      end
      busy_r    <= '0;
      dis_vld_r <= '0;
      out_vld_r <= 1'b0;
    end
    else
    begin
      if (cdb_r.vld)
      begin
        busy_r[cdb_r.tag] <= 1'b0;
        // A later rename of the same register keeps the register waiting
        if (ren_vld_r[cdb_r.wa] && (ren_tag_r[cdb_r.wa] == cdb_r.tag))
        begin
          regs_r[cdb_r.wa]    <= cdb_r.data;
          ren_vld_r[cdb_r.wa] <= 1'b0;
        end
      end
      // Renaming comes last so it wins over a broadcast to the same register
      if (inst_adv)
      begin
        busy_r[new_tag]     <= 1'b1;
        ren_vld_r[inst.wa]  <= 1'b1;
      end
      dis_vld_r <= inst_adv ? (stn ? 2'b10 : 2'b01) : 2'b00;
      out_vld_r <= cdb_r.vld;
    end
  end

  always_ff @(posedge clk)
  begin
    if (inst_adv)
    begin
      ren_tag_r[inst.wa] <= new_tag;
      dis_r              <= dis_w;
    end
    out_wa_r    <= cdb_r.wa;
    out_wdata_r <= cdb_r.data;
  end

  // Every broadcast must belong to a tag handed out earlier and not yet retired
  a_cdb_tag_busy: assert property (@(posedge clk) disable iff (rst)
    cdb_r.vld |-> busy_r[cdb_r.tag])
    else $error("CDB broadcast of an idle tag");

endmodule

`default_nettype wire

//--- verilog/tomasulo_inst_fifo.sv
// Instruction queue of 2**FIFO_DEPTH_LOG2 entries; the caller must gate push with the full flag
`timescale 1ns/1ps
`default_nettype none

module tomasulo_inst_fifo #(
  parameter int FIFO_DEPTH_LOG2 = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                push,
  input  tomasulo_pkg::inst_t push_inst,
  output logic                full_r,
  output tomasulo_pkg::inst_t inst,
  output logic                inst_vld,
  input  logic                inst_adv
);
  import tomasulo_pkg::*;

  localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

  // The top bit of each pointer is the wrap bit
  logic [FIFO_DEPTH_LOG2:0] wr_ptr_r;
  logic [FIFO_DEPTH_LOG2:0] wr_ptr_w;
  logic [FIFO_DEPTH_LOG2:0] rd_ptr_r;
  logic [FIFO_DEPTH_LOG2:0] rd_ptr_w;
  logic                     empty_r;
  logic                     empty_w;
  logic                     full_w;
  inst_t                    mem_r [DEPTH];

  always_comb
  begin
    wr_ptr_w = push ? (wr_ptr_r + 1'b1) : wr_ptr_r;
    rd_ptr_w = inst_adv ? (rd_ptr_r + 1'b1) : rd_ptr_r;
    empty_w  = (rd_ptr_w == wr_ptr_w);
    // Same index but different laps means the writer is a full lap ahead
    full_w   = (rd_ptr_w[FIFO_DEPTH_LOG2] != wr_ptr_w[FIFO_DEPTH_LOG2]) &&
               (rd_ptr_w[FIFO_DEPTH_LOG2-1:0] == wr_ptr_w[FIFO_DEPTH_LOG2-1:0]);
  end

  // Head is read straight from the array, so it is valid one cycle after the write
  assign inst     = mem_r[rd_ptr_r[FIFO_DEPTH_LOG2-1:0]];
  assign inst_vld = ~empty_r;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      empty_r  <= 1'b1;
      full_r   <= 1'b0;
    end
    else
    begin
      wr_ptr_r <= wr_ptr_w;
      rd_ptr_r <= rd_ptr_w;
      empty_r  <= empty_w;
      full_r   <= full_w;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem_r[wr_ptr_r[FIFO_DEPTH_LOG2-1:0]] <= push_inst;
  end

  // The front end must respect the registered full flag
  a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full_r)
    else $error("push into full instruction queue");

endmodule

`default_nettype wire

//--- verilog/tomasulo_pkg.sv
// Shared types; tag_t is {station, entry}, station 0 is arithmetic, and SCH_W must exceed every latency
`default_nettype none

package tomasulo_pkg;

  // Data word carried on the CDB and held in the register file
  typedef logic [15:0] word_t;

  // Eight architectural registers
  typedef logic [2:0] reg_t;

  // The encoding 2'b11 is unused and yields zero in the pipelines
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MPY = 2'd2
  } opcode_t;

  // Bit 1 selects the station, bit 0 the rename slot within it
  typedef logic [1:0] tag_t;

  // Entries per reservation station
  localparam int RS_ENTRIES_N = 2;

  // Slot scheduler width, one bit per future CDB cycle
  localparam int SCH_W = 8;

  // One instruction as it waits in the queue
  typedef struct packed {
    opcode_t op;
    reg_t    wa;
    reg_t    ra0;
    reg_t    ra1;
  } inst_t;

  // A source operand holds either its value or the tag that will produce it
  typedef struct packed {
    logic  rdy;
    tag_t  tag;
    word_t val;
  } operand_t;

  // Dispatcher to station
  typedef struct packed {
    opcode_t        op;
    reg_t           wa;
    tag_t           tag;
    operand_t [1:0] src;
  } dispatch_t;

  // Station to pipeline, both operand values resolved
  typedef struct packed {
    opcode_t     op;
    reg_t        wa;
    tag_t        tag;
    word_t [1:0] val;
  } issue_t;

  // One result on the common data bus; all fields are zero when idle
  typedef struct packed {
    logic  vld;
    tag_t  tag;
    reg_t  wa;
    word_t data;
  } cdb_t;

endpackage

`default_nettype wire
